// ==== all.f ====
source/gain_pkg.sv
source/sample_stream_if.sv
source/sample_capture.sv
source/coef_mult_pipe.sv
source/scale_mult_pipe.sv
source/gain_datapath.sv
source/output_limiter.sv
source/audio_gain_top.sv
verification/tb_clock_gen.sv
verification/audio_gain_properties.sv
verification/audio_gain_tb.sv

// ==== verification/audio_gain_tb.sv ====
// Audio gain stage testbench
`timescale 1ns/1ps
`default_nettype none

module audio_gain_tb;

  typedef logic [gain_pkg::SAMPLE_W-1:0] smp_t;
  typedef logic [gain_pkg::COEF_W-1:0]   coef_t;
  typedef logic [gain_pkg::SCALE_W-1:0]  scale_t;

  typedef struct {
    smp_t                 sample;
    coef_t                coef;
    scale_t               scale;
    gain_pkg::gain_mode_e mode;
    smp_t                 exp_sample;
    logic                 exp_clip;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  smp_t                 sample_i;
  logic                 sample_valid_i;
  coef_t                coef_i;
  scale_t               scale_i;
  gain_pkg::gain_mode_e mode_i;
  smp_t                 sample_o;
  logic                 sample_valid_o;
  logic                 clip_o;

  row_t table_q[$];
  smp_t exp_sample_q[$];
  logic exp_clip_q[$];
  smp_t exp_s;
  logic exp_c;
  int   seed = 83;
  int   r;
  int   cycles = 0;
  int   limit = 0;
  int   checked = 0;

  tb_clock_gen clock_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  audio_gain_top dut_i (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .coef_i         (coef_i),
    .scale_i        (scale_i),
    .mode_i         (mode_i),
    .sample_o       (sample_o),
    .sample_valid_o (sample_valid_o),
    .clip_o         (clip_o)
  );

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  function automatic smp_t clamp_sample(input longint v, output logic clipped);
    longint hi;
    longint lo;
    hi = longint'($signed(gain_pkg::SAMPLE_POS_FS));
    lo = longint'($signed(gain_pkg::SAMPLE_NEG_FS));
    clipped = (v > hi) || (v < lo);
    if (v > hi) return gain_pkg::SAMPLE_POS_FS;
    if (v < lo) return gain_pkg::SAMPLE_NEG_FS;
    return v[gain_pkg::SAMPLE_W-1:0];
  endfunction

  // Reference model, arithmetic shifts floor toward minus infinity
  function automatic row_t make_row(input smp_t sample, input coef_t coef,
                                    input scale_t scale, input gain_pkg::gain_mode_e mode);
    row_t   rw;
    longint p1;
    longint p2;
    smp_t   mid;
    smp_t   sat;
    logic   c1;
    logic   c2;
    rw.sample = sample;
    rw.coef   = coef;
    rw.scale  = scale;
    rw.mode   = mode;
    p1  = (longint'($signed(sample)) * longint'($signed(coef))) >>> gain_pkg::COEF_SHIFT;
    mid = clamp_sample(p1, c1);
    p2  = (longint'($signed(mid)) * longint'(scale)) >>> gain_pkg::SCALE_SHIFT;
    sat = clamp_sample(p2, c2);
    case (mode)
      gain_pkg::MODE_BYPASS: begin
        rw.exp_sample = sample;
        rw.exp_clip   = 1'b0;
      end
      gain_pkg::MODE_MUTE: begin
        rw.exp_sample = '0;
        rw.exp_clip   = 1'b0;
      end
      gain_pkg::MODE_INVERT: begin
        // A clipped result sits past a rail, so inversion lands on the other one
        if (c1 || c2 || sat == gain_pkg::SAMPLE_NEG_FS) begin
          rw.exp_sample = sat[gain_pkg::SAMPLE_W-1] ? gain_pkg::SAMPLE_POS_FS :
                                                      gain_pkg::SAMPLE_NEG_FS;
          rw.exp_clip   = 1'b1;
        end else begin
          rw.exp_sample = -sat;
          rw.exp_clip   = 1'b0;
        end
      end
      default: begin
        rw.exp_sample = sat;
        rw.exp_clip   = c1 | c2;
      end
    endcase
    return rw;
  endfunction

  task automatic add_row(input smp_t s, input coef_t c, input scale_t sc,
                         input gain_pkg::gain_mode_e m);
    table_q.push_back(make_row(s, c, sc, m));
  endtask

  task automatic check_sample(input string name, input smp_t got, input smp_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s: got 0x%06h expected 0x%06h", name, got, exp));
    end
  endtask

  task automatic check_clip(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  initial begin
    // Strobes held during reset must vanish
    sample_i       = 24'h5A5A5A;
    sample_valid_i = 1'b1;
    coef_i         = 24'h080000;
    scale_i        = 32'h0100_0000;
    mode_i         = gain_pkg::MODE_GAIN;

    // Unity, fractional and negative operands
    add_row(24'h123456, 24'h080000, 32'h0100_0000, gain_pkg::MODE_GAIN);
    add_row(24'hF00001, 24'h080000, 32'h0100_0000, gain_pkg::MODE_GAIN);
    add_row(24'h000003, 24'h040000, 32'h0100_0000, gain_pkg::MODE_GAIN);
    add_row(24'hFFFFFD, 24'h040000, 32'h0100_0000, gain_pkg::MODE_GAIN);
    add_row(24'h000005, 24'hFE0000, 32'h0100_0000, gain_pkg::MODE_GAIN);
    add_row(24'h100000, 24'h080000, 32'h00C0_0000, gain_pkg::MODE_GAIN);
    add_row(24'hFFFFFF, 24'h080000, 32'h0080_0000, gain_pkg::MODE_GAIN);
    // Intermediate and output saturation
    add_row(24'h7FFFFF, 24'h7FFFFF, 32'h0100_0000, gain_pkg::MODE_GAIN);
    add_row(24'h800001, 24'h7FFFFF, 32'h0100_0000, gain_pkg::MODE_GAIN);
    add_row(24'h200000, 24'h080000, 32'h0800_0000, gain_pkg::MODE_GAIN);
    add_row(24'hE00000, 24'h080000, 32'h0800_0000, gain_pkg::MODE_GAIN);
    // Remaining modes
    add_row(24'h654321, 24'h7FFFFF, 32'h0800_0000, gain_pkg::MODE_BYPASS);
    add_row(24'h7FFFFF, 24'h7FFFFF, 32'h0800_0000, gain_pkg::MODE_MUTE);
    add_row(24'h001000, 24'h080000, 32'h0100_0000, gain_pkg::MODE_INVERT);
    add_row(24'h800000, 24'h080000, 32'h0100_0000, gain_pkg::MODE_INVERT);
    // Coefficients within +-4.0 and scales from 1.0 up to 4.0
    // A scale of at least 1.0 keeps an intermediate clamp on its rail
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      add_row(smp_t'($random(seed)), coef_t'($random(seed) % (1 << 21)),
              32'h0100_0000 + {$random(seed)} % 32'h0300_0000,
              gain_pkg::gain_mode_e'(r[1:0]));
    end
    limit = table_q.size() + gain_pkg::TOTAL_LAT + 50;

    @(posedge rst_n);
    sample_valid_i = 1'b0;
    foreach (table_q[i]) begin
      @(posedge clk);
      #1;
      sample_i       = table_q[i].sample;
      coef_i         = table_q[i].coef;
      scale_i        = table_q[i].scale;
      mode_i         = table_q[i].mode;
      sample_valid_i = 1'b1;
      exp_sample_q.push_back(table_q[i].exp_sample);
      exp_clip_q.push_back(table_q[i].exp_clip);
    end
    @(posedge clk);
    #1;
    sample_valid_i = 1'b0;

    wait (exp_sample_q.size() == 0);
    repeat (gain_pkg::TOTAL_LAT + 2) @(posedge clk);
    if (checked == table_q.size() && dut_i.props_i.failures == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d of %0d outputs checked with %0d assertion failures",
                              checked, table_q.size(), dut_i.props_i.failures));
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (dut_i.props_i.failures != 0) begin
      stop_on_error("A protocol assertion on the DUT failed");
    end
    if (rst_n && sample_valid_o) begin
      if (exp_sample_q.size() == 0) begin
        stop_on_error("Output strobe arrived with no sample in flight");
      end else begin
        exp_s = exp_sample_q.pop_front();
        exp_c = exp_clip_q.pop_front();
        check_sample("sample_o", sample_o, exp_s);
        check_clip("clip_o", clip_o, exp_c);
        checked++;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
        stop_on_error("Timeout, expected outputs are missing");
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/audio_gain_properties.sv ====
// Gain stage protocol properties
`timescale 1ns/1ps
`default_nettype none

module audio_gain_properties (
  input wire logic                          clk,
  input wire logic                          rst_n_i,
  input wire logic                          valid_in_i,
  input wire logic                          valid_out_i,
  input wire logic [gain_pkg::SAMPLE_W-1:0] sample_out_i,
  input wire logic                          clip_out_i
);

  int unsigned since_rst;
  // Count of failed assertions, read by the testbench
  int unsigned failures = 0;

  // Cycles since reset release, saturating at the pipeline depth
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      since_rst <= 0;
    end else if (since_rst < gain_pkg::TOTAL_LAT) begin
      since_rst <= since_rst + 1;
    end
  end

  valid_forward: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_in_i |-> ##(gain_pkg::TOTAL_LAT) valid_out_i)
    else begin
      failures++;
      $error("Input strobe without output strobe after the pipeline latency");
    end

  valid_backward: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_out_i |-> $past(valid_in_i, gain_pkg::TOTAL_LAT))
    else begin
      failures++;
      $error("Output strobe without matching input strobe");
    end

  quiet_after_reset: assert property (@(posedge clk)
    (since_rst < gain_pkg::TOTAL_LAT) |-> !valid_out_i)
    else begin
      failures++;
      $error("Output strobe during reset or the pipeline fill");
    end

  clip_at_rail: assert property (@(posedge clk) disable iff (!rst_n_i)
    clip_out_i |-> (sample_out_i == gain_pkg::SAMPLE_POS_FS ||
                    sample_out_i == gain_pkg::SAMPLE_NEG_FS))
    else begin
      failures++;
      $error("Clip flag with a sample off the rails");
    end

endmodule

bind audio_gain_top audio_gain_properties props_i (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .valid_in_i   (sample_valid_i),
  .valid_out_i  (sample_valid_o),
  .sample_out_i (sample_o),
  .clip_out_i   (clip_o)
);

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns period
  initial clk_o = 1'b0;
  always #4 clk_o = ~clk_o;

  // Release just after an edge, ten cycles in
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== source/audio_gain_top.sv ====
// Mono audio gain stage
`timescale 1ns/1ps
`default_nettype none

module audio_gain_top (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  input  wire logic [gain_pkg::SAMPLE_W-1:0] sample_i,
  input  wire logic                          sample_valid_i,
  input  wire logic [gain_pkg::COEF_W-1:0]   coef_i,
  input  wire logic [gain_pkg::SCALE_W-1:0]  scale_i,
  input  wire gain_pkg::gain_mode_e          mode_i,
  output logic [gain_pkg::SAMPLE_W-1:0]      sample_o,
  output logic                               sample_valid_o,
  output logic                               clip_o
);

  logic [gain_pkg::COEF_W-1:0]       coef;
  logic [gain_pkg::SCALE_W-1:0]      scale;
  logic [gain_pkg::SCALE_PROD_W-1:0] wide;
  logic [gain_pkg::SAMPLE_W-1:0]     bypass;

  sample_stream_if capture_if ();
  sample_stream_if proc_if ();

  sample_capture capture_i (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .coef_i         (coef_i),
    .scale_i        (scale_i),
    .mode_i         (mode_i),
    .out            (capture_if.src),
    .coef_o         (coef),
    .scale_o        (scale)
  );

  gain_datapath datapath_i (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .in       (capture_if.dst),
    .coef_i   (coef),
    .scale_i  (scale),
    .out      (proc_if.src),
    .wide_o   (wide),
    .bypass_o (bypass)
  );

  output_limiter limiter_i (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .in             (proc_if.dst),
    .wide_i         (wide),
    .bypass_i       (bypass),
    .sample_o       (sample_o),
    .sample_valid_o (sample_valid_o),
    .clip_o         (clip_o)
  );

endmodule

`default_nettype wire

// ==== source/output_limiter.sv ====
// Output saturation and mode select
`timescale 1ns/1ps
`default_nettype none

module output_limiter (
  input  wire logic                                clk,
  input  wire logic                                rst_n_i,
  sample_stream_if.dst                             in,
  input  wire logic [gain_pkg::SCALE_PROD_W-1:0]   wide_i,
  input  wire logic [gain_pkg::SAMPLE_W-1:0]       bypass_i,
  output logic [gain_pkg::SAMPLE_W-1:0]            sample_o,
  output logic                                     sample_valid_o,
  output logic                                     clip_o
);

  localparam int SW = gain_pkg::SAMPLE_W;
  localparam int PW = gain_pkg::SCALE_PROD_W;

  logic          fits;
  logic [SW-1:0] sat_val;
  logic          gain_clip;
  logic [SW-1:0] res;
  logic          res_clip;

  // Upper bits must all equal the sign of the 24-bit result
  assign fits      = (&wide_i[PW-1:SW-1]) | ~(|wide_i[PW-1:SW-1]);
  assign sat_val   = fits ? in.sample :
                     (wide_i[PW-1] ? gain_pkg::SAMPLE_NEG_FS : gain_pkg::SAMPLE_POS_FS);
  assign gain_clip = ~fits | in.clip;

  always_comb begin
    res      = sat_val;
    res_clip = gain_clip;
    case (in.mode)
      gain_pkg::MODE_GAIN: begin
        res      = sat_val;
        res_clip = gain_clip;
      end
      gain_pkg::MODE_BYPASS: begin
        res      = bypass_i;
        res_clip = 1'b0;
      end
      gain_pkg::MODE_MUTE: begin
        res      = '0;
        res_clip = 1'b0;
      end
      gain_pkg::MODE_INVERT: begin
        // A clipped value lies beyond a rail, so its negation hits the other rail
        if (gain_clip || sat_val == gain_pkg::SAMPLE_NEG_FS) begin
          res      = sat_val[SW-1] ? gain_pkg::SAMPLE_POS_FS : gain_pkg::SAMPLE_NEG_FS;
          res_clip = 1'b1;
        end else begin
          res      = -sat_val;
          res_clip = 1'b0;
        end
      end
      default: begin
        res      = sat_val;
        res_clip = gain_clip;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sample_valid_o <= 1'b0;
      clip_o         <= 1'b0;
    end else begin
      sample_valid_o <= in.valid;
      clip_o         <= in.valid & res_clip;
    end
  end

  always_ff @(posedge clk) begin
    sample_o <= res;
  end

endmodule

`default_nettype wire

// ==== source/gain_datapath.sv ====
// Gain and scale processing chain
`timescale 1ns/1ps
`default_nettype none

module gain_datapath (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  sample_stream_if.dst                       in,
  input  wire logic [gain_pkg::COEF_W-1:0]   coef_i,
  input  wire logic [gain_pkg::SCALE_W-1:0]  scale_i,
  sample_stream_if.src                       out,
  output logic [gain_pkg::SCALE_PROD_W-1:0]  wide_o,
  output logic [gain_pkg::SAMPLE_W-1:0]      bypass_o
);

  localparam int LA = gain_pkg::COEF_LAT;
  localparam int LB = gain_pkg::SCALE_LAT;
  localparam int SW = gain_pkg::SAMPLE_W;

  // Side band matching the coefficient multiplier
  logic [LA-1:0]               valid_a;
  gain_pkg::gain_mode_e        mode_a  [LA];
  logic [gain_pkg::SCALE_W-1:0] scale_a [LA];
  logic [SW-1:0]               smp_a   [LA];

  // Side band matching the scale multiplier
  logic [LB-1:0]               valid_b;
  gain_pkg::gain_mode_e        mode_b  [LB];
  logic [SW-1:0]               smp_b   [LB];
  logic                        clip_b  [LB];

  logic [gain_pkg::COEF_PROD_W-1:0]  coef_prod;
  logic                              mid_fits;
  logic [SW-1:0]                     mid_sample;
  logic                              mid_clip;
  logic [gain_pkg::SCALE_PROD_W-1:0] scale_prod;

  coef_mult_pipe coef_mult_i (
    .clk (clk),
    .a_i (in.sample),
    .b_i (coef_i),
    .p_o (coef_prod)
  );

  // Clamp the Q4.19 product back into the sample range
  assign mid_fits   = (&coef_prod[gain_pkg::COEF_PROD_W-1:SW-1]) |
                      ~(|coef_prod[gain_pkg::COEF_PROD_W-1:SW-1]);
  assign mid_sample = mid_fits ? coef_prod[SW-1:0] :
                      (coef_prod[gain_pkg::COEF_PROD_W-1] ? gain_pkg::SAMPLE_NEG_FS :
                                                            gain_pkg::SAMPLE_POS_FS);
  assign mid_clip   = ~mid_fits;

  scale_mult_pipe scale_mult_i (
    .clk (clk),
    .a_i (mid_sample),
    .b_i (scale_a[LA-1]),
    .p_o (scale_prod)
  );

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_a <= '0;
      valid_b <= '0;
    end else begin
      valid_a <= {valid_a[LA-2:0], in.valid};
      valid_b <= {valid_b[LB-2:0], valid_a[LA-1]};
    end
  end

  always_ff @(posedge clk) begin
    mode_a[0]  <= in.mode;
    scale_a[0] <= scale_i;
    smp_a[0]   <= in.sample;
    for (int i = 1; i < LA; i++) begin
      mode_a[i]  <= mode_a[i-1];
      scale_a[i] <= scale_a[i-1];
      smp_a[i]   <= smp_a[i-1];
    end
    // Intermediate clip joins here, in step with the clamped value
    mode_b[0] <= mode_a[LA-1];
    smp_b[0]  <= smp_a[LA-1];
    clip_b[0] <= mid_clip;
    for (int j = 1; j < LB; j++) begin
      mode_b[j] <= mode_b[j-1];
      smp_b[j]  <= smp_b[j-1];
      clip_b[j] <= clip_b[j-1];
    end
  end

  assign out.valid  = valid_b[LB-1];
  assign out.mode   = mode_b[LB-1];
  assign out.clip   = clip_b[LB-1];
  // Low bits are the final value only when the limiter finds no overflow
  assign out.sample = scale_prod[SW-1:0];
  assign wide_o     = scale_prod;
  assign bypass_o   = smp_b[LB-1];

endmodule

`default_nettype wire

// ==== source/scale_mult_pipe.sv ====
// Pipelined master scale multiplier
`timescale 1ns/1ps
`default_nettype none

module scale_mult_pipe (
  input  wire logic                                 clk,
  input  wire logic signed [gain_pkg::SAMPLE_W-1:0] a_i,
  input  wire logic [gain_pkg::SCALE_W-1:0]         b_i,
  output logic [gain_pkg::SCALE_PROD_W-1:0]         p_o
);

  localparam int DLY = gain_pkg::SCALE_LAT - 1;

  logic signed [gain_pkg::SAMPLE_W-1:0]     a_d [DLY];
  logic [gain_pkg::SCALE_W-1:0]             b_d [DLY];
  logic signed [gain_pkg::SCALE_W:0]        b_ext;
  logic signed [gain_pkg::SCALE_FULL_W-1:0] prod_full;
  logic signed [gain_pkg::SCALE_FULL_W-1:0] prod_q;

  // Five operand stages, the sixth register holds the product
  always_ff @(posedge clk) begin
    a_d[0] <= a_i;
    b_d[0] <= b_i;
    for (int i = 1; i < DLY; i++) begin
      a_d[i] <= a_d[i-1];
      b_d[i] <= b_d[i-1];
    end
  end

  // Scale is unsigned, extend with a zero so it never turns negative
  assign b_ext = $signed({1'b0, b_d[DLY-1]});

  // Full product fits in 56 bits for any operand pair
  assign prod_full = a_d[DLY-1] * b_ext;

  always_ff @(posedge clk) begin
    prod_q <= prod_full;
  end

  // Bits 55..24
  assign p_o = prod_q[gain_pkg::SCALE_SHIFT +: gain_pkg::SCALE_PROD_W];

endmodule

`default_nettype wire

// ==== source/coef_mult_pipe.sv ====
// Pipelined coefficient multiplier
`timescale 1ns/1ps
`default_nettype none

module coef_mult_pipe (
  input  wire logic                                 clk,
  input  wire logic signed [gain_pkg::SAMPLE_W-1:0] a_i,
  input  wire logic signed [gain_pkg::COEF_W-1:0]   b_i,
  output logic [gain_pkg::COEF_PROD_W-1:0]          p_o
);

  logic signed [gain_pkg::SAMPLE_W-1:0]    a_d [gain_pkg::COEF_LAT];
  logic signed [gain_pkg::COEF_W-1:0]      b_d [gain_pkg::COEF_LAT];
  logic signed [gain_pkg::COEF_FULL_W-1:0] prod_full;

  // Operand delay line, one product per cycle in flight
  always_ff @(posedge clk) begin
    a_d[0] <= a_i;
    b_d[0] <= b_i;
    for (int i = 1; i < gain_pkg::COEF_LAT; i++) begin
      a_d[i] <= a_d[i-1];
      b_d[i] <= b_d[i-1];
    end
  end

  assign prod_full = a_d[gain_pkg::COEF_LAT-1] * b_d[gain_pkg::COEF_LAT-1];

  // Bits 46..19, i.e. the product rescaled by 2^-19 with floor
  assign p_o = prod_full[gain_pkg::COEF_SHIFT +: gain_pkg::COEF_PROD_W];

endmodule

`default_nettype wire

// ==== source/sample_capture.sv ====
// Input operand capture
`timescale 1ns/1ps
`default_nettype none

module sample_capture (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  input  wire logic [gain_pkg::SAMPLE_W-1:0] sample_i,
  input  wire logic                          sample_valid_i,
  input  wire logic [gain_pkg::COEF_W-1:0]   coef_i,
  input  wire logic [gain_pkg::SCALE_W-1:0]  scale_i,
  input  wire gain_pkg::gain_mode_e          mode_i,
  sample_stream_if.src                       out,
  output logic [gain_pkg::COEF_W-1:0]        coef_o,
  output logic [gain_pkg::SCALE_W-1:0]       scale_o
);

  logic                          valid_q;
  logic [gain_pkg::SAMPLE_W-1:0] sample_q;
  gain_pkg::gain_mode_e          mode_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sample_valid_i;
    end
  end

  // Operands are bound to the sample present on the strobe
  always_ff @(posedge clk) begin
    if (sample_valid_i) begin
      sample_q <= sample_i;
      coef_o   <= coef_i;
      scale_o  <= scale_i;
      mode_q   <= mode_i;
    end
  end

  assign out.valid  = valid_q;
  assign out.sample = sample_q;
  assign out.mode   = mode_q;
  // Nothing clamps at this point
  assign out.clip   = 1'b0;

endmodule

`default_nettype wire

// ==== source/sample_stream_if.sv ====
// Internal sample stream
`timescale 1ns/1ps
`default_nettype none

interface sample_stream_if;

  logic [gain_pkg::SAMPLE_W-1:0] sample;
  logic                          valid;
  gain_pkg::gain_mode_e          mode;
  // Set when a stage had to clamp this sample
  logic                          clip;

  modport src (
    output sample,
    output valid,
    output mode,
    output clip
  );

  modport dst (
    input sample,
    input valid,
    input mode,
    input clip
  );

endinterface

`default_nettype wire

// ==== source/gain_pkg.sv ====
// Audio gain stage definitions
`default_nettype none

package gain_pkg;

  // Data widths
  localparam int SAMPLE_W = 24;
  localparam int COEF_W   = 24;
  localparam int SCALE_W  = 32;

  // Full product widths of both multipliers
  localparam int COEF_FULL_W  = SAMPLE_W + COEF_W - 1;
  localparam int SCALE_FULL_W = SAMPLE_W + SCALE_W;

  // Coefficient is Q4.19, so the kept window starts at bit 19
  localparam int COEF_PROD_W = 28;
  localparam int COEF_SHIFT  = 19;

  // Master scale is Q8.24, kept window starts at bit 24
  localparam int SCALE_PROD_W = 32;
  localparam int SCALE_SHIFT  = 24;

  // Register stages per block
  localparam int COEF_LAT  = 5;
  localparam int SCALE_LAT = 6;
  // Capture, both multipliers and the output register
  localparam int TOTAL_LAT = 1 + COEF_LAT + SCALE_LAT + 1;

  // Rails of the signed sample range
  localparam logic [SAMPLE_W-1:0] SAMPLE_POS_FS = {1'b0, {(SAMPLE_W - 1){1'b1}}};
  localparam logic [SAMPLE_W-1:0] SAMPLE_NEG_FS = {1'b1, {(SAMPLE_W - 1){1'b0}}};

  typedef enum logic [1:0] {
    MODE_GAIN   = 2'd0,
    MODE_BYPASS = 2'd1,
    MODE_MUTE   = 2'd2,
    MODE_INVERT = 2'd3
  } gain_mode_e;

endpackage

`default_nettype wire
